/* src/rv_decode_defs.svh */
`ifndef RV_DECODE_DEFS_SVH
`define RV_DECODE_DEFS_SVH

// datapath and instruction word width
`define XLEN   32

// register index width, x0..x31
`define REG_AW 5

////////////////////////////////////////////////////////////
// RV32 base opcodes, bits [6:0]
////////////////////////////////////////////////////////////
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_OP     7'b0110011   // reg-reg, incl. M extension
`define OP_OPIMM  7'b0010011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_SYSTEM 7'b1110011   // csr access, ecall/ebreak

`endif

/* src/rv_decode_pkg.sv */
`include "rv_decode_defs.svh"

package rv_decode_pkg;

  ////////////////////////////////////////////////////////////
  // instruction word, one view per encoding format
  ////////////////////////////////////////////////////////////
  typedef union packed {
    struct packed {
      logic [6:0]         funct7;
      logic [`REG_AW-1:0] rs2;
      logic [`REG_AW-1:0] rs1;
      logic [2:0]         funct3;
      logic [`REG_AW-1:0] rd;
      logic [6:0]         opcode;
    } r_fmt;
    struct packed {
      logic [11:0]        imm12;
      logic [`REG_AW-1:0] rs1;
      logic [2:0]         funct3;
      logic [`REG_AW-1:0] rd;
      logic [6:0]         opcode;
    } i_fmt;
    struct packed {
      logic [6:0]         imm_hi;   // imm[11:5]
      logic [`REG_AW-1:0] rs2;
      logic [`REG_AW-1:0] rs1;
      logic [2:0]         funct3;
      logic [4:0]         imm_lo;   // imm[4:0]
      logic [6:0]         opcode;
    } s_fmt;
    struct packed {
      logic               imm12;
      logic [5:0]         imm10_5;
      logic [`REG_AW-1:0] rs2;
      logic [`REG_AW-1:0] rs1;
      logic [2:0]         funct3;
      logic [3:0]         imm4_1;
      logic               imm11;
      logic [6:0]         opcode;
    } b_fmt;
    struct packed {
      logic [19:0]        imm20;    // also carries the scrambled J immediate
      logic [`REG_AW-1:0] rd;
      logic [6:0]         opcode;
    } u_fmt;
  } instr_u;

  // decoded control word, 45 bits
  typedef struct packed {
    logic [2:0] alusel;
    logic [2:0] mulsel;
    logic [2:0] divsel;
    logic [2:0] csrsel;
    logic [2:0] storecntrl;  // sw,sh,sb
    logic [4:0] loadcntrl;   // lhu,lbu,lw,lh,lb
    logic [3:0] cmpcntrl;    // sltiu,slti,sltu,slt
    logic       branch;
    logic       beq;
    logic       bne;
    logic       blt;
    logic       bge;
    logic       bltu;
    logic       bgeu;
    logic       memread;
    logic       memwrite;
    logic       regwrite;
    logic       alusrc;
    logic       compare;
    logic       auipc;
    logic       lui;
    logic       jal;
    logic       jalr;
    logic       illegal_ins;
    logic       csrwrite;
    logic       csrread;
    logic       mul_inst;
    logic       div_inst;
  } ctrl_t;

  // ID/EX pipeline word
  typedef struct packed {
    logic [`XLEN-1:0]   pc;
    ctrl_t              ctrl;
    logic [`XLEN-1:0]   imm;
    logic [`REG_AW-1:0] rs1;
    logic [`REG_AW-1:0] rs2;
    logic [`REG_AW-1:0] rd;
    logic [2:0]         funct3;
  } id_ex_t;

endpackage

/* src/control.sv */
`timescale 1ns/1ps
`include "rv_decode_defs.svh"

module control
(
  input  rv_decode_pkg::instr_u instr,
  input  logic                  flush,
  input  logic                  hazard,
  output rv_decode_pkg::ctrl_t  ctrl
);

  logic stall;
  logic rd_zero;
  logic rs1_zero;

  assign stall    = flush || hazard || (instr == '0);  // zero word counts as a nop
  assign rd_zero  = (instr.r_fmt.rd == '0);
  assign rs1_zero = (instr.r_fmt.rs1 == '0);

  ////////////////////////////////////////////////////////////
  // main decode
  ////////////////////////////////////////////////////////////
  always_comb
  begin
    ctrl = '0;

    unique case (instr.r_fmt.opcode)
      `OP_LOAD:
      begin
        ctrl.memread  = 1'b1;
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;  // base + offset on the adder
        unique case (instr.r_fmt.funct3)
          3'b000:  ctrl.loadcntrl   = 5'b00001;  // lb
          3'b001:  ctrl.loadcntrl   = 5'b00010;  // lh
          3'b010:  ctrl.loadcntrl   = 5'b00100;  // lw
          3'b100:  ctrl.loadcntrl   = 5'b01000;  // lbu
          3'b101:  ctrl.loadcntrl   = 5'b10000;  // lhu
          default: ctrl.illegal_ins = 1'b1;
        endcase
      end
      `OP_OP:
      begin
        ctrl.regwrite = 1'b1;
        unique case ({instr.r_fmt.funct7, instr.r_fmt.funct3})
          {7'h00, 3'b000}: ctrl.alusel = 3'b000;  // add
          {7'h20, 3'b000}: ctrl.alusel = 3'b001;  // sub
          {7'h00, 3'b001}: ctrl.alusel = 3'b101;  // sll
          {7'h00, 3'b010}:                        // slt
          begin
            ctrl.compare  = 1'b1;
            ctrl.cmpcntrl = 4'b0001;
          end
          {7'h00, 3'b011}:                        // sltu
          begin
            ctrl.compare  = 1'b1;
            ctrl.cmpcntrl = 4'b0010;
          end
          {7'h00, 3'b100}: ctrl.alusel = 3'b100;  // xor
          {7'h00, 3'b101}: ctrl.alusel = 3'b110;  // srl
          {7'h20, 3'b101}: ctrl.alusel = 3'b111;  // sra
          {7'h00, 3'b110}: ctrl.alusel = 3'b011;  // or
          {7'h00, 3'b111}: ctrl.alusel = 3'b010;  // and
          // M extension, funct3 picks the op
          {7'h01, 3'b000},
          {7'h01, 3'b001},
          {7'h01, 3'b010},
          {7'h01, 3'b011}:
          begin
            ctrl.mul_inst = 1'b1;
            ctrl.mulsel   = {1'b0, instr.r_fmt.funct3[1:0]} + 3'd1;  // mul..mulhu -> 1..4
          end
          {7'h01, 3'b100},
          {7'h01, 3'b101},
          {7'h01, 3'b110},
          {7'h01, 3'b111}:
          begin
            ctrl.div_inst = 1'b1;
            ctrl.divsel   = {1'b0, instr.r_fmt.funct3[1:0]} + 3'd1;  // div..remu -> 1..4
          end
          default: ctrl.illegal_ins = 1'b1;
        endcase
      end
      `OP_OPIMM:
      begin
        ctrl.regwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
        unique case (instr.r_fmt.funct3)
          3'b000: ctrl.alusel = 3'b000;  // addi
          3'b001:                        // slli, shamt only
            if (instr.r_fmt.funct7 == 7'h00)
              ctrl.alusel = 3'b101;
            else
              ctrl.illegal_ins = 1'b1;
          3'b010:                        // slti
          begin
            ctrl.compare  = 1'b1;
            ctrl.cmpcntrl = 4'b0100;
          end
          3'b011:                        // sltiu
          begin
            ctrl.compare  = 1'b1;
            ctrl.cmpcntrl = 4'b1000;
          end
          3'b100: ctrl.alusel = 3'b100;  // xori
          3'b101:
            unique case (instr.r_fmt.funct7)
              7'h00:   ctrl.alusel      = 3'b110;  // srli
              7'h20:   ctrl.alusel      = 3'b111;  // srai
              default: ctrl.illegal_ins = 1'b1;
            endcase
          3'b110: ctrl.alusel = 3'b011;  // ori
          3'b111: ctrl.alusel = 3'b010;  // andi
        endcase
      end
      `OP_STORE:
      begin
        ctrl.memwrite = 1'b1;
        ctrl.alusrc   = 1'b1;
        unique case (instr.r_fmt.funct3)
          3'b000:  ctrl.storecntrl  = 3'b001;  // sb
          3'b001:  ctrl.storecntrl  = 3'b010;  // sh
          3'b010:  ctrl.storecntrl  = 3'b100;  // sw
          default: ctrl.illegal_ins = 1'b1;
        endcase
      end
      `OP_BRANCH:
      begin
        ctrl.branch = 1'b1;
        unique case (instr.r_fmt.funct3)
          3'b000:  ctrl.beq         = 1'b1;
          3'b001:  ctrl.bne         = 1'b1;
          3'b100:  ctrl.blt         = 1'b1;
          3'b101:  ctrl.bge         = 1'b1;
          3'b110:  ctrl.bltu        = 1'b1;
          3'b111:  ctrl.bgeu        = 1'b1;
          default: ctrl.illegal_ins = 1'b1;
        endcase
      end
      `OP_JAL:
      begin
        ctrl.jal      = 1'b1;
        ctrl.regwrite = 1'b1;  // link register
      end
      `OP_JALR:
      begin
        ctrl.jalr     = 1'b1;
        ctrl.regwrite = 1'b1;
      end
      `OP_LUI:
      begin
        ctrl.lui      = 1'b1;
        ctrl.alusrc   = 1'b1;
        ctrl.regwrite = 1'b1;
      end
      `OP_AUIPC:
      begin
        ctrl.auipc    = 1'b1;
        ctrl.alusrc   = 1'b1;
        ctrl.regwrite = 1'b1;
      end
      `OP_SYSTEM:
      begin
        ctrl.csrsel = instr.r_fmt.funct3;
        unique case (instr.r_fmt.funct3)
          3'b001,                        // csrrw, csrrwi
          3'b101:
          begin
            ctrl.alusrc   = instr.r_fmt.funct3[2];  // uimm in the rs1 slot
            ctrl.regwrite = !rd_zero;
            ctrl.csrread  = !rd_zero;               // no side-effect read for rd = x0
            ctrl.csrwrite = 1'b1;
          end
          3'b010, 3'b011,                // csrrs, csrrc and the imm forms
          3'b110, 3'b111:
          begin
            ctrl.alusrc   = instr.r_fmt.funct3[2];
            ctrl.regwrite = 1'b1;
            ctrl.csrread  = 1'b1;
            ctrl.csrwrite = !rs1_zero;              // x0 mask means read only
          end
          default: ;                     // ecall/ebreak, nothing here
        endcase
      end
      default: ctrl.illegal_ins = 1'b1;
    endcase

    // kill state updates of a stalled slot
    if (stall)
    begin
      ctrl.regwrite = 1'b0;
      ctrl.memwrite = 1'b0;
      ctrl.csrwrite = 1'b0;
      ctrl.csrread  = 1'b0;
    end

    // control flow and traps only dropped on flush
    if (flush)
    begin
      ctrl.jal         = 1'b0;
      ctrl.jalr        = 1'b0;
      ctrl.branch      = 1'b0;
      ctrl.illegal_ins = 1'b0;
    end
  end

  // one-hot encodings must survive every case arm
  always_comb
  begin
    a_load_onehot0: assert ($onehot0(ctrl.loadcntrl));
    a_store_onehot0: assert ($onehot0(ctrl.storecntrl));
    a_branch_kind: assert ($onehot0({ctrl.beq, ctrl.bne, ctrl.blt,
                                      ctrl.bge, ctrl.bltu, ctrl.bgeu}));
    a_mem_excl: assert (!(ctrl.memread && ctrl.memwrite));
  end

endmodule

/* src/imm_gen.sv */
`timescale 1ns/1ps
`include "rv_decode_defs.svh"

module imm_gen
(
  input  rv_decode_pkg::instr_u instr,
  output logic [`XLEN-1:0]      imm
);

  // everything sign extends from instr[31]
  always_comb
  begin
    case (instr.r_fmt.opcode)
      `OP_LOAD,
      `OP_OPIMM,
      `OP_JALR,
      `OP_SYSTEM:  // I format
        imm = {{20{instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
      `OP_STORE:   // S format
        imm = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
      `OP_BRANCH:  // B format, halfword aligned
        imm = {{19{instr.b_fmt.imm12}},
               instr.b_fmt.imm12,
               instr.b_fmt.imm11,
               instr.b_fmt.imm10_5,
               instr.b_fmt.imm4_1,
               1'b0};
      `OP_LUI,
      `OP_AUIPC:   // U format
        imm = {instr.u_fmt.imm20, 12'h000};
      `OP_JAL:
      begin
        // J format shares the U slot, bits reordered
        imm = {{12{instr.u_fmt.imm20[19]}},
               instr.u_fmt.imm20[7:0],    // imm[19:12]
               instr.u_fmt.imm20[8],      // imm[11]
               instr.u_fmt.imm20[18:9],   // imm[10:1]
               1'b0};
      end
      default:
        imm = '0;
    endcase
  end

endmodule

/* src/hazard_unit.sv */
`timescale 1ns/1ps
`include "rv_decode_defs.svh"

module hazard_unit
(
  input  logic                  clk,
  input  rv_decode_pkg::instr_u instr,
  input  logic [`REG_AW-1:0]    ex_rd,
  input  logic                  ex_memread,
  output logic                  hazard
);

  logic [6:0] opcode;
  logic       use_rs2;
  logic       rs1_hit;
  logic       rs2_hit;
  logic       ex_load;

  assign opcode = instr.r_fmt.opcode;

  // only R, S and B formats carry a real rs2
  assign use_rs2 = (opcode == `OP_OP) || (opcode == `OP_STORE) || (opcode == `OP_BRANCH);

  assign rs1_hit = (instr.r_fmt.rs1 == ex_rd);
  assign rs2_hit = use_rs2 && (instr.r_fmt.rs2 == ex_rd);

  // load in EX writing a real register
  assign ex_load = ex_memread && (ex_rd != '0);

  assign hazard = ex_load && (rs1_hit || rs2_hit);

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////
  // the bubble behind a load-use stall frees the slot again
  a_single_stall: assert property (@(posedge clk) hazard |=> !hazard);

endmodule

/* src/id_ex_reg.sv */
`timescale 1ns/1ps
`include "rv_decode_defs.svh"

module id_ex_reg
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [`XLEN-1:0]      pc,
  input  rv_decode_pkg::instr_u instr,
  input  rv_decode_pkg::ctrl_t  ctrl,
  input  logic [`XLEN-1:0]      imm,
  input  logic                  flush,
  input  logic                  hazard,
  output rv_decode_pkg::id_ex_t id_ex
);

  logic bubble;

  // zero word is a bubble too
  assign bubble = flush || hazard || (instr == '0);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      id_ex <= '0;
    end
    else
    begin
      id_ex.pc     <= pc;
      id_ex.imm    <= imm;
      id_ex.rs1    <= instr.r_fmt.rs1;
      id_ex.rs2    <= instr.r_fmt.rs2;
      id_ex.rd     <= instr.r_fmt.rd;
      id_ex.funct3 <= instr.r_fmt.funct3;
      if (bubble)
        id_ex.ctrl <= '0;    // nop into EX
      else
        id_ex.ctrl <= ctrl;
    end
  end

  ////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////
  // a flushed slot must not write anything in later stages
  a_flush_quiet: assert property (
    @(posedge clk) disable iff (!rst_n)
    flush |=> (!id_ex.ctrl.regwrite && !id_ex.ctrl.memwrite)
  );

endmodule

/* src/rv_decode_stage.sv */
`timescale 1ns/1ps
`include "rv_decode_defs.svh"

module rv_decode_stage
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  rv_decode_pkg::instr_u instr,
  input  logic [`XLEN-1:0]      pc,
  input  logic                  flush,        // taken branch/jump in EX
  output rv_decode_pkg::id_ex_t id_ex,
  output logic                  stall_fetch
);

  import rv_decode_pkg::*;

  ctrl_t            ctrl;
  logic [`XLEN-1:0] imm;
  logic             hazard;

  // load-use check against the slot now in EX
  hazard_unit u_hazard
  (
    .clk        (clk),
    .instr      (instr),
    .ex_rd      (id_ex.rd),
    .ex_memread (id_ex.ctrl.memread),
    .hazard     (hazard)
  );

  control u_control
  (
    .instr  (instr),
    .flush  (flush),
    .hazard (hazard),
    .ctrl   (ctrl)
  );

  imm_gen u_imm_gen
  (
    .instr (instr),
    .imm   (imm)
  );

  id_ex_reg u_id_ex_reg
  (
    .clk    (clk),
    .rst_n  (rst_n),
    .pc     (pc),
    .instr  (instr),
    .ctrl   (ctrl),
    .imm    (imm),
    .flush  (flush),
    .hazard (hazard),
    .id_ex  (id_ex)
  );

  assign stall_fetch = hazard;  // fetch holds instr and pc one more cycle

endmodule

/* sim/rv_decode_stage_tb.sv */
`timescale 1ns/1ps
`include "rv_decode_defs.svh"

module rv_decode_stage_tb;

  import rv_decode_pkg::*;

  // one table row, stimulus plus expected decode
  typedef struct packed {
    logic [31:0] ins;
    logic [31:0] pc;
    logic        flush;
    logic        hold;    // fetch repeats the word after the stall
    logic        stall;   // stall_fetch in the first cycle
    logic [2:0]  alusel;
    logic [2:0]  mulsel;
    logic [2:0]  divsel;
    logic [4:0]  loadc;
    logic [2:0]  storec;
    logic [3:0]  cmpc;
    logic [2:0]  csrs;
    logic [20:0] key;     // flag bits, see key_of()
    logic [31:0] imm;
  } row_t;

  // flag positions inside key_of()
  localparam logic [20:0] k_rw    = 21'h000001;
  localparam logic [20:0] k_mr    = 21'h000002;
  localparam logic [20:0] k_mw    = 21'h000004;
  localparam logic [20:0] k_as    = 21'h000008;
  localparam logic [20:0] k_cmp   = 21'h000010;
  localparam logic [20:0] k_br    = 21'h000020;
  localparam logic [20:0] k_beq   = 21'h000040;
  localparam logic [20:0] k_bgeu  = 21'h000800;
  localparam logic [20:0] k_jal   = 21'h001000;
  localparam logic [20:0] k_jalr  = 21'h002000;
  localparam logic [20:0] k_lui   = 21'h004000;
  localparam logic [20:0] k_auipc = 21'h008000;
  localparam logic [20:0] k_ill   = 21'h010000;
  localparam logic [20:0] k_cw    = 21'h020000;
  localparam logic [20:0] k_cr    = 21'h040000;
  localparam logic [20:0] k_mul   = 21'h080000;
  localparam logic [20:0] k_div   = 21'h100000;

  logic             clk;
  logic             rst_n;
  instr_u           instr;
  logic [`XLEN-1:0] pc;
  logic             flush;
  id_ex_t           id_ex;
  logic             stall_fetch;

  row_t   rows[64];
  string  names[64];
  int     row_cnt;
  int     error_count;
  int     pass_count;
  logic   row_ok;
  integer seed;

  rv_decode_stage uut
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr       (instr),
    .pc          (pc),
    .flush       (flush),
    .id_ex       (id_ex),
    .stall_fetch (stall_fetch)
  );

  initial
  begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // instruction encoders, straight from the ISA formats
  ////////////////////////////////////////////////////////////
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, `OP_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], `OP_STORE};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `OP_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
  endfunction

  // flags gathered into one word, bit 0 is regwrite
  function automatic logic [20:0] key_of(input ctrl_t c);
    return {c.div_inst, c.mul_inst, c.csrread, c.csrwrite, c.illegal_ins,
            c.auipc, c.lui, c.jalr, c.jal, c.bgeu, c.bltu, c.bge, c.blt,
            c.bne, c.beq, c.branch, c.compare, c.alusrc, c.memwrite,
            c.memread, c.regwrite};
  endfunction

  ////////////////////////////////////////////////////////////
  // table building
  ////////////////////////////////////////////////////////////
  task automatic add_row(input string nm, input logic [31:0] ins, input logic fl,
                         input logic [20:0] key, input logic [31:0] imm);
    rows[row_cnt]       = '0;
    rows[row_cnt].ins   = ins;
    rows[row_cnt].pc    = 32'h0000_1000 + row_cnt * 4;
    rows[row_cnt].flush = fl;
    rows[row_cnt].key   = key;
    rows[row_cnt].imm   = imm;
    names[row_cnt]      = nm;
    row_cnt++;
  endtask

  // selects of the row just added
  task automatic set_sel(input logic [2:0] alu, input logic [2:0] mul, input logic [2:0] dv,
                         input logic [4:0] ld, input logic [2:0] st, input logic [3:0] cmp);
    rows[row_cnt - 1].alusel = alu;
    rows[row_cnt - 1].mulsel = mul;
    rows[row_cnt - 1].divsel = dv;
    rows[row_cnt - 1].loadc  = ld;
    rows[row_cnt - 1].storec = st;
    rows[row_cnt - 1].cmpc   = cmp;
  endtask

  // csr op of the row just added
  task automatic set_csr(input logic [2:0] sel);
    rows[row_cnt - 1].csrs = sel;
  endtask

  task automatic set_hold();
    rows[row_cnt - 1].hold  = 1'b1;
    rows[row_cnt - 1].stall = 1'b1;
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    logic [2:0]  f3;
    logic [2:0]  alu;
    int          k;
    add_row("add", enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), 1'b0, k_rw, 32'h0);
    add_row("sub", enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd4), 1'b0, k_rw, 32'h0);
    set_sel(3'd1, 3'd0, 3'd0, 5'd0, 3'd0, 4'd0);
    add_row("sra", enc_r(7'h20, 5'd2, 5'd1, 3'd5, 5'd5), 1'b0, k_rw, 32'h0);
    set_sel(3'd7, 3'd0, 3'd0, 5'd0, 3'd0, 4'd0);
    add_row("slt", enc_r(7'h00, 5'd2, 5'd1, 3'd2, 5'd6), 1'b0, k_rw | k_cmp, 32'h0);
    set_sel(3'd0, 3'd0, 3'd0, 5'd0, 3'd0, 4'b0001);
    add_row("mul", enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd7), 1'b0, k_rw | k_mul, 32'h0);
    set_sel(3'd0, 3'd1, 3'd0, 5'd0, 3'd0, 4'd0);
    add_row("divu", enc_r(7'h01, 5'd2, 5'd1, 3'd5, 5'd8), 1'b0, k_rw | k_div, 32'h0);
    set_sel(3'd0, 3'd0, 3'd2, 5'd0, 3'd0, 4'd0);
    add_row("addi", enc_i(12'hffb, 5'd1, 3'd0, 5'd9, `OP_OPIMM), 1'b0, k_rw | k_as,
            32'hffff_fffb);
    add_row("srai", enc_i(12'h403, 5'd1, 3'd5, 5'd10, `OP_OPIMM), 1'b0, k_rw | k_as,
            32'h0000_0403);
    set_sel(3'd7, 3'd0, 3'd0, 5'd0, 3'd0, 4'd0);
    add_row("lw", enc_i(12'h008, 5'd2, 3'd2, 5'd11, `OP_LOAD), 1'b0, k_rw | k_mr | k_as, 32'h8);
    set_sel(3'd0, 3'd0, 3'd0, 5'b00100, 3'd0, 4'd0);
    add_row("lbu", enc_i(12'hfff, 5'd3, 3'd4, 5'd12, `OP_LOAD), 1'b0, k_rw | k_mr | k_as,
            32'hffff_ffff);
    set_sel(3'd0, 3'd0, 3'd0, 5'b01000, 3'd0, 4'd0);
    add_row("sw", enc_s(12'h00c, 5'd13, 5'd4, 3'd2), 1'b0, k_mw | k_as, 32'hc);
    set_sel(3'd0, 3'd0, 3'd0, 5'd0, 3'b100, 4'd0);
    add_row("sb", enc_s(12'hff0, 5'd14, 5'd5, 3'd0), 1'b0, k_mw | k_as, 32'hffff_fff0);
    set_sel(3'd0, 3'd0, 3'd0, 5'd0, 3'b001, 4'd0);
    add_row("beq", enc_b(13'h0010, 5'd2, 5'd1, 3'd0), 1'b0, k_br | k_beq, 32'h10);
    add_row("bgeu", enc_b(13'h1ff8, 5'd4, 5'd3, 3'd7), 1'b0, k_br | k_bgeu, 32'hffff_fff8);
    add_row("jal", enc_j(21'h000800, 5'd1), 1'b0, k_jal | k_rw, 32'h800);
    add_row("jalr", enc_i(12'h004, 5'd5, 3'd0, 5'd1, `OP_JALR), 1'b0, k_jalr | k_rw, 32'h4);
    add_row("lui", {20'h12345, 5'd15, `OP_LUI}, 1'b0, k_lui | k_as | k_rw, 32'h1234_5000);
    add_row("auipc", {20'hfffff, 5'd16, `OP_AUIPC}, 1'b0, k_auipc | k_as | k_rw,
            32'hffff_f000);
    add_row("csrrw", enc_i(12'h300, 5'd1, 3'd1, 5'd17, `OP_SYSTEM), 1'b0,
            k_rw | k_cw | k_cr, 32'h300);
    set_csr(3'd1);
    add_row("csrrs", enc_i(12'h300, 5'd2, 3'd2, 5'd18, `OP_SYSTEM), 1'b0,
            k_rw | k_cw | k_cr, 32'h300);
    set_csr(3'd2);
    add_row("csrrs_x0", enc_i(12'h341, 5'd0, 3'd2, 5'd19, `OP_SYSTEM), 1'b0, k_rw | k_cr,
            32'h341);
    set_csr(3'd2);
    add_row("csrrw_rd0", enc_i(12'h300, 5'd3, 3'd1, 5'd0, `OP_SYSTEM), 1'b0, k_cw, 32'h300);
    set_csr(3'd1);

    // random op-imm rows, logic ops only so funct7 stays free
    for (k = 0; k < 4; k++)
    begin
      rnd = $random(seed);
      case (rnd[1:0])
        2'd0:    f3 = 3'b000;  // addi
        2'd1:    f3 = 3'b100;  // xori
        2'd2:    f3 = 3'b110;  // ori
        default: f3 = 3'b111;  // andi
      endcase
      case (rnd[1:0])
        2'd0:    alu = 3'd0;
        2'd1:    alu = 3'd4;
        2'd2:    alu = 3'd3;
        default: alu = 3'd2;
      endcase
      add_row("opimm_rand", enc_i(rnd[31:20], rnd[19:15], f3, rnd[11:7], `OP_OPIMM), 1'b0,
              k_rw | k_as, {{20{rnd[31]}}, rnd[31:20]});
      set_sel(alu, 3'd0, 3'd0, 5'd0, 3'd0, 4'd0);
    end

    // illegal words, then the same words flushed
    add_row("bad_load", enc_i(12'h000, 5'd1, 3'd3, 5'd20, `OP_LOAD), 1'b0,
            k_rw | k_mr | k_as | k_ill, 32'h0);
    add_row("bad_load_fl", enc_i(12'h000, 5'd1, 3'd3, 5'd20, `OP_LOAD), 1'b1, '0, 32'h0);
    add_row("bad_slli", enc_i(12'h021, 5'd1, 3'd1, 5'd21, `OP_OPIMM), 1'b0,
            k_rw | k_as | k_ill, 32'h21);
    add_row("bad_slli_fl", enc_i(12'h021, 5'd1, 3'd1, 5'd21, `OP_OPIMM), 1'b1, '0, 32'h21);
    add_row("bad_opcode", 32'h0000_007f, 1'b0, k_ill, 32'h0);
    add_row("bad_opcode_fl", 32'h0000_007f, 1'b1, '0, 32'h0);

    // load-use pair, then a load to x0
    add_row("lw_x5", enc_i(12'h000, 5'd1, 3'd2, 5'd5, `OP_LOAD), 1'b0, k_rw | k_mr | k_as,
            32'h0);
    set_sel(3'd0, 3'd0, 3'd0, 5'b00100, 3'd0, 4'd0);
    add_row("add_use_x5", enc_r(7'h00, 5'd1, 5'd5, 3'd0, 5'd6), 1'b0, k_rw, 32'h0);
    set_hold();
    add_row("lw_x0", enc_i(12'h004, 5'd1, 3'd2, 5'd0, `OP_LOAD), 1'b0, k_rw | k_mr | k_as,
            32'h4);
    set_sel(3'd0, 3'd0, 3'd0, 5'b00100, 3'd0, 4'd0);
    add_row("add_use_x0", enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd6), 1'b0, k_rw, 32'h0);

    // bubbles
    add_row("zero_word", 32'h0, 1'b0, '0, 32'h0);
    add_row("sw_flushed", enc_s(12'h00c, 5'd13, 5'd4, 3'd2), 1'b1, '0, 32'hc);
    add_row("jal_flushed", enc_j(21'h000800, 5'd1), 1'b1, '0, 32'h800);
  endtask

  ////////////////////////////////////////////////////////////
  // checking
  ////////////////////////////////////////////////////////////
  task automatic report_fail(input string sig, input logic [63:0] exp, input logic [63:0] act);
    error_count++;
    row_ok = 1'b0;
    $display("Fail at %0t: %s expected %0h, got %0h", $time, sig, exp, act);
  endtask

  task automatic check_slot(input row_t r, input logic bubble);
    logic zero_exp;
    zero_exp = bubble ||
               ({r.alusel, r.mulsel, r.divsel, r.loadc, r.storec, r.cmpc, r.csrs,
                 r.key} == '0);
    if (id_ex.pc !== r.pc)
      report_fail("id_ex.pc", 64'(r.pc), 64'(id_ex.pc));
    if (id_ex.imm !== r.imm)
      report_fail("id_ex.imm", 64'(r.imm), 64'(id_ex.imm));
    if (id_ex.rd !== r.ins[11:7])
      report_fail("id_ex.rd", 64'(r.ins[11:7]), 64'(id_ex.rd));
    if (id_ex.rs1 !== r.ins[19:15])
      report_fail("id_ex.rs1", 64'(r.ins[19:15]), 64'(id_ex.rs1));
    if (id_ex.rs2 !== r.ins[24:20])
      report_fail("id_ex.rs2", 64'(r.ins[24:20]), 64'(id_ex.rs2));
    if (id_ex.funct3 !== r.ins[14:12])
      report_fail("id_ex.funct3", 64'(r.ins[14:12]), 64'(id_ex.funct3));
    if (zero_exp)
    begin
      if (id_ex.ctrl !== '0)  // nop in EX
        report_fail("id_ex.ctrl", 64'd0, 64'(id_ex.ctrl));
    end
    else
    begin
      if (id_ex.ctrl.alusel !== r.alusel)
        report_fail("alusel", 64'(r.alusel), 64'(id_ex.ctrl.alusel));
      if (id_ex.ctrl.mulsel !== r.mulsel)
        report_fail("mulsel", 64'(r.mulsel), 64'(id_ex.ctrl.mulsel));
      if (id_ex.ctrl.divsel !== r.divsel)
        report_fail("divsel", 64'(r.divsel), 64'(id_ex.ctrl.divsel));
      if (id_ex.ctrl.loadcntrl !== r.loadc)
        report_fail("loadcntrl", 64'(r.loadc), 64'(id_ex.ctrl.loadcntrl));
      if (id_ex.ctrl.storecntrl !== r.storec)
        report_fail("storecntrl", 64'(r.storec), 64'(id_ex.ctrl.storecntrl));
      if (id_ex.ctrl.cmpcntrl !== r.cmpc)
        report_fail("cmpcntrl", 64'(r.cmpc), 64'(id_ex.ctrl.cmpcntrl));
      if (id_ex.ctrl.csrsel !== r.csrs)
        report_fail("csrsel", 64'(r.csrs), 64'(id_ex.ctrl.csrsel));
      if (key_of(id_ex.ctrl) !== r.key)
        report_fail("ctrl flags", 64'(r.key), 64'(key_of(id_ex.ctrl)));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////
  initial
  begin : main
    row_t r;
    int   i;
    rst_n       = 1'b0;
    instr       = '0;
    pc          = '0;
    flush       = 1'b0;
    seed        = 32'h80c1_5997;
    row_cnt     = 0;
    error_count = 0;
    pass_count  = 0;
    build_table();

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n  = 1'b1;
    row_ok = 1'b1;
    if (id_ex.ctrl !== '0)
      report_fail("id_ex.ctrl", 64'd0, 64'(id_ex.ctrl));
    if (stall_fetch !== 1'b0)
      report_fail("stall_fetch", 64'd0, 64'(stall_fetch));
    if (row_ok)
      pass_count++;
    $display("reset: %s", row_ok ? "ok" : "mismatch");

    for (i = 0; i < row_cnt; i++)
    begin
      r      = rows[i];
      row_ok = 1'b1;
      @(negedge clk);
      instr = r.ins;
      pc    = r.pc;
      flush = r.flush;
      #1;
      if (stall_fetch !== r.stall)
        report_fail("stall_fetch", 64'(r.stall), 64'(stall_fetch));
      @(posedge clk);
      #1;
      check_slot(r, r.stall);  // stalled slot goes out as a bubble
      if (r.hold)
      begin
        @(negedge clk);        // same word, fetch held
        #1;
        if (stall_fetch !== 1'b0)
          report_fail("stall_fetch", 64'd0, 64'(stall_fetch));
        @(posedge clk);
        #1;
        check_slot(r, 1'b0);
      end
      if (row_ok)
        pass_count++;
      $display("row %0d (%s): %s", i, names[i], row_ok ? "ok" : "mismatch");
    end

    $display("%0d tests, %0d ok, %0d errors", row_cnt + 1, pass_count, error_count);
    if (error_count == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

  // cycle limit scales with the table
  initial
  begin : watchdog
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (cycles < row_cnt * 3 + 20)
    begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not complete within %0d cycles", cycles);
    $display("Finished with errors");
    $finish;
  end

endmodule

/* rv_decode_stage.f */
+incdir+src
src/rv_decode_pkg.sv
src/control.sv
src/imm_gen.sv
src/hazard_unit.sv
src/id_ex_reg.sv
src/rv_decode_stage.sv
sim/rv_decode_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the decode stage testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
  --top-module rv_decode_stage_tb \
  -f rv_decode_stage.f

./obj_dir/Vrv_decode_stage_tb | tee sim.log

if grep -q "Finished with no errors" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed, see sim.log"
  exit 1
fi
